/* include/led_panel_defines.svh */
`ifndef LED_PANEL_DEFINES_SVH
`define LED_PANEL_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Panel geometry
//////////////////////////////////////////////////////////////////////

// Parallel driver chains, one sin line each
`define LED_CHAINS 4

// Scan lines in one frame
`define LINES 4

// Words shifted into each chain per line
`define WORDS_PER_LINE 4

// Grayscale word width
`define PIXEL_BITS 16

//////////////////////////////////////////////////////////////////////
// Buffering and timing
//////////////////////////////////////////////////////////////////////

// Pixel FIFO entries, also the emulator's starting credit count
`define FIFO_DEPTH 8

// clock_33 cycles with gclk held low after each vsync
`define BLANKING_CYCLES 80

`endif

/* led_panel_top.f */
+incdir+include
source/led_panel_pkg.sv
source/driver_conf_pkg.sv
source/framebuffer_emulator.sv
source/pixel_fifo.sv
source/driver_controller.sv
source/gclk_generator.sv
source/led_panel_top.sv
testbench/led_panel_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the LED panel testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f led_panel_top.f --top-module led_panel_tb

./obj_dir/Vled_panel_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failures"

/* source/driver_conf_pkg.sv */
package driver_conf_pkg;

  // Serial lengths of the fixed sequences
  localparam int CONF_BITS  = 48;
  localparam int VSYNC_BITS = 16;

  // Commands, selected by the number of sclk pulses with lat high
  typedef enum logic [1:0] {
    CMD_DATA_LATCH = 2'd0,
    CMD_VSYNC      = 2'd1,
    CMD_CONF_WRITE = 2'd2
  } drv_cmd_t;

  typedef logic [CONF_BITS-1:0] conf_word_t;

  //////////////////////////////////////////////////////////////////////
  // Configuration word
  //////////////////////////////////////////////////////////////////////

  // Line count, PWM mode, current gain and the like
  // Bits 6:0 stay zero here, that field is the brightness
  localparam conf_word_t conf_fixed = 48'h1A05_4FC3_2280;

  function automatic logic [3:0] lat_width(input drv_cmd_t cmd);
    case (cmd)
      CMD_DATA_LATCH: return 4'd1;
      CMD_VSYNC:      return 4'd3;
      default:        return 4'd11;
    endcase
  endfunction

  function automatic conf_word_t make_conf(input logic [6:0] brightness);
    return {conf_fixed[CONF_BITS-1:7], brightness};
  endfunction

endpackage

/* source/driver_controller.sv */
`timescale 1ns/100ps
`include "led_panel_defines.svh"

module driver_controller (
  input  logic                               clock_33,
  input  logic                               nrst,
  input  logic [6:0]                         brightness,
  input  logic                               fifo_empty,
  input  logic [`LED_CHAINS*`PIXEL_BITS-1:0] fifo_data,
  input  logic                               fifo_sof,
  output logic                               fifo_pop,
  output logic                               sclk,
  output logic                               lat,
  output logic [`LED_CHAINS-1:0]             sin,
  output logic                               vsync_done
);

  localparam int SHW = driver_conf_pkg::CONF_BITS;
  localparam int BCW = $clog2(SHW);
  localparam int WCW = $clog2(`WORDS_PER_LINE);
  localparam int LCW = $clog2(`LINES);
  localparam int BLW = $clog2(`BLANKING_CYCLES + 1);

  led_panel_pkg::ctrl_state_t state;
  driver_conf_pkg::drv_cmd_t  cmd;
  logic [SHW-1:0]             shreg [`LED_CHAINS];
  logic [BCW-1:0]             bit_cnt;
  logic [3:0]                 lat_cnt;
  logic [WCW-1:0]             word_cnt;
  logic [LCW-1:0]             line_cnt;
  logic [BLW-1:0]             blank_cnt;
  logic [6:0]                 conf_bright;
  logic                       phase;
  logic                       do_latch;
  logic                       frame_end;
  logic                       conf_done;
  logic                       start_conf;
  logic                       start_data;
  logic                       shifting;
  logic                       lat_end;
  logic [WCW-1:0]             cur_word;
  logic [LCW-1:0]             cur_line;

  // Brightness is compared only when the head word opens a frame
  always_comb begin
    start_conf = 1'b0;
    start_data = 1'b0;
    if (state == led_panel_pkg::ST_IDLE) begin
      if (!conf_done) begin
        start_conf = 1'b1;
      end else if (!fifo_empty) begin
        if (fifo_sof && (brightness != conf_bright)) begin
          start_conf = 1'b1;
        end else begin
          start_data = 1'b1;
        end
      end
    end
  end

  assign fifo_pop = start_data;
  assign shifting = (state == led_panel_pkg::ST_CONF_SHIFT) ||
                    (state == led_panel_pkg::ST_DATA_SHIFT) ||
                    (state == led_panel_pkg::ST_VSYNC);
  // Falling sclk edge of the last lat pulse
  assign lat_end  = phase & lat & (lat_cnt == 4'd1);
  // A sof word resyncs the line and word position
  assign cur_word = fifo_sof ? '0 : word_cnt;
  assign cur_line = fifo_sof ? '0 : line_cnt;

  always_comb begin
    for (int c = 0; c < `LED_CHAINS; c++) begin
      sin[c] = shreg[c][SHW-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      state <= led_panel_pkg::ST_IDLE;
      cmd <= driver_conf_pkg::CMD_DATA_LATCH;
      for (int c = 0; c < `LED_CHAINS; c++) begin
        shreg[c] <= '0;
      end
      bit_cnt <= '0;
      lat_cnt <= '0;
      word_cnt <= '0;
      line_cnt <= '0;
      blank_cnt <= '0;
      conf_bright <= '0;
      phase <= 1'b0;
      do_latch <= 1'b0;
      frame_end <= 1'b0;
      conf_done <= 1'b0;
      sclk <= 1'b0;
      lat <= 1'b0;
      vsync_done <= 1'b0;
    end else begin
      vsync_done <= 1'b0;
      // Phase 0 raises sclk, phase 1 lowers it and moves to the next bit
      if (shifting || state == led_panel_pkg::ST_LATCH) begin
        phase <= ~phase;
      end
      case (state)
        led_panel_pkg::ST_IDLE: begin
          if (start_conf) begin
            for (int c = 0; c < `LED_CHAINS; c++) begin
              shreg[c] <= driver_conf_pkg::make_conf(brightness);
            end
            conf_bright <= brightness;
            bit_cnt <= BCW'(SHW - 1);
            cmd <= driver_conf_pkg::CMD_CONF_WRITE;
            do_latch <= 1'b1;
            state <= led_panel_pkg::ST_CONF_SHIFT;
          end else if (start_data) begin
            for (int c = 0; c < `LED_CHAINS; c++) begin
              shreg[c] <= {fifo_data[c*`PIXEL_BITS +: `PIXEL_BITS], {(SHW - `PIXEL_BITS){1'b0}}};
            end
            bit_cnt <= BCW'(`PIXEL_BITS - 1);
            cmd <= driver_conf_pkg::CMD_DATA_LATCH;
            do_latch <= (cur_word == WCW'(`WORDS_PER_LINE - 1));
            frame_end <= (cur_line == LCW'(`LINES - 1));
            if (cur_word == WCW'(`WORDS_PER_LINE - 1)) begin
              word_cnt <= '0;
              line_cnt <= (cur_line == LCW'(`LINES - 1)) ? '0 : cur_line + 1'b1;
            end else begin
              word_cnt <= cur_word + 1'b1;
              line_cnt <= cur_line;
            end
            state <= led_panel_pkg::ST_DATA_SHIFT;
          end
        end
        led_panel_pkg::ST_CONF_SHIFT, led_panel_pkg::ST_DATA_SHIFT, led_panel_pkg::ST_VSYNC: begin
          if (!phase) begin
            sclk <= 1'b1;
            // lat goes up together with sclk on the last bit
            if (bit_cnt == '0 && do_latch) begin
              lat <= 1'b1;
              lat_cnt <= driver_conf_pkg::lat_width(cmd);
            end
          end else begin
            sclk <= 1'b0;
            for (int c = 0; c < `LED_CHAINS; c++) begin
              shreg[c] <= {shreg[c][SHW-2:0], 1'b0};
            end
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == '0) begin
              if (!do_latch) begin
                state <= led_panel_pkg::ST_IDLE;
              end else if (!lat_end) begin
                lat_cnt <= lat_cnt - 4'd1;
                state <= led_panel_pkg::ST_LATCH;
              end
            end
          end
        end
        led_panel_pkg::ST_LATCH: begin
          // Extra sclk pulses with sin held low
          sclk <= ~phase;
          if (phase) begin
            lat_cnt <= lat_cnt - 4'd1;
          end
        end
        led_panel_pkg::ST_BLANK: begin
          blank_cnt <= blank_cnt - 1'b1;
          if (blank_cnt == BLW'(1)) begin
            state <= led_panel_pkg::ST_IDLE;
          end
        end
        default: state <= led_panel_pkg::ST_IDLE;
      endcase

      // What follows a finished command
      if (lat_end) begin
        lat <= 1'b0;
        case (cmd)
          driver_conf_pkg::CMD_CONF_WRITE: begin
            conf_done <= 1'b1;
            state <= led_panel_pkg::ST_IDLE;
          end
          driver_conf_pkg::CMD_DATA_LATCH: begin
            if (frame_end) begin
              // Shift register is already all zero here
              bit_cnt <= BCW'(driver_conf_pkg::VSYNC_BITS - 1);
              cmd <= driver_conf_pkg::CMD_VSYNC;
              state <= led_panel_pkg::ST_VSYNC;
            end else begin
              state <= led_panel_pkg::ST_IDLE;
            end
          end
          default: begin
            vsync_done <= 1'b1;
            blank_cnt <= BLW'(`BLANKING_CYCLES);
            state <= led_panel_pkg::ST_BLANK;
          end
        endcase
      end
    end
  end

endmodule

/* source/framebuffer_emulator.sv */
`timescale 1ns/100ps
`include "led_panel_defines.svh"

module framebuffer_emulator (
  input  logic                               clock_33,
  input  logic                               nrst,
  input  led_panel_pkg::pattern_t            pattern_sel,
  output logic                               word_valid,
  output logic [`LED_CHAINS*`PIXEL_BITS-1:0] word_data,
  output logic                               word_sof,
  input  logic                               credit_return
);

  localparam int CRW = $clog2(`FIFO_DEPTH + 1);
  localparam int WCW = $clog2(`WORDS_PER_LINE);
  localparam int LCW = $clog2(`LINES);

  logic [CRW-1:0]          credits;
  logic [WCW-1:0]          word_cnt;
  logic [LCW-1:0]          line_cnt;
  logic [15:0]             frame_cnt;
  led_panel_pkg::pattern_t pat_q;
  led_panel_pkg::pattern_t cur_pat;
  logic                    send;
  logic                    frame_start;

  function automatic led_panel_pkg::pixel_t pixel_word(
    input led_panel_pkg::pattern_t pat,
    input int c,
    input int l,
    input int w,
    input logic [15:0] f
  );
    case (pat)
      led_panel_pkg::PAT_SOLID:   return '1;
      led_panel_pkg::PAT_RAMP:    return led_panel_pkg::pixel_t'(l * `WORDS_PER_LINE + w + c * 256);
      led_panel_pkg::PAT_CHECKER: return ((l + w + c) % 2 != 0) ? '1 : '0;
      default:                    return led_panel_pkg::pixel_t'(f);
    endcase
  endfunction

  // One word per cycle as long as a FIFO slot is owed to us
  assign send        = (credits != '0);
  assign frame_start = (word_cnt == '0) && (line_cnt == '0);
  // Pattern is picked up with the first word of a frame
  assign cur_pat     = frame_start ? pattern_sel : pat_q;

  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      credits    <= CRW'(`FIFO_DEPTH);
      word_valid <= 1'b0;
      word_sof   <= 1'b0;
      word_cnt   <= '0;
      line_cnt   <= '0;
      frame_cnt  <= '0;
      pat_q      <= led_panel_pkg::PAT_SOLID;
    end else begin
      credits    <= credits - CRW'(send) + CRW'(credit_return);
      word_valid <= send;
      if (send) begin
        word_sof <= frame_start;
        pat_q    <= cur_pat;
        if (word_cnt == WCW'(`WORDS_PER_LINE - 1)) begin
          word_cnt <= '0;
          if (line_cnt == LCW'(`LINES - 1)) begin
            line_cnt  <= '0;
            frame_cnt <= frame_cnt + 16'd1;
          end else begin
            line_cnt <= line_cnt + 1'b1;
          end
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // Chain c sits at bits c*PIXEL_BITS upward
  always_ff @(posedge clock_33) begin
    if (send) begin
      for (int c = 0; c < `LED_CHAINS; c++) begin
        word_data[c*`PIXEL_BITS +: `PIXEL_BITS] <=
          pixel_word(cur_pat, c, int'(line_cnt), int'(word_cnt), frame_cnt);
      end
    end
  end

endmodule

/* source/gclk_generator.sv */
`timescale 1ns/100ps
`include "led_panel_defines.svh"

module gclk_generator (
  input  logic clock_33,
  input  logic nrst,
  input  logic vsync_done,
  output logic gclk
);

  localparam int BW = $clog2(`BLANKING_CYCLES);

  // Cycles of blanking still to go
  logic [BW-1:0] blank_cnt;

  // Set by the first vsync, gclk stays low before that
  logic running;

  //////////////////////////////////////////////////////////////////////
  // Grayscale clock
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      blank_cnt <= '0;
      running   <= 1'b0;
      gclk      <= 1'b0;
    end else begin
      if (vsync_done) begin
        // Low from the next cycle on for BLANKING_CYCLES cycles
        blank_cnt <= BW'(`BLANKING_CYCLES - 1);
        running   <= 1'b1;
        gclk      <= 1'b0;
      end else if (blank_cnt != '0) begin
        blank_cnt <= blank_cnt - 1'b1;
      end else if (running) begin
        // Half the clock_33 rate
        gclk <= ~gclk;
      end
    end
  end

endmodule

/* source/led_panel_pkg.sv */
`include "led_panel_defines.svh"

package led_panel_pkg;

  // One grayscale word for one chain
  typedef logic [`PIXEL_BITS-1:0] pixel_t;

  // Test patterns of the framebuffer emulator
  typedef enum logic [1:0] {
    PAT_SOLID    = 2'd0,
    PAT_RAMP     = 2'd1,
    PAT_CHECKER  = 2'd2,
    PAT_FRAME_ID = 2'd3
  } pattern_t;

  //////////////////////////////////////////////////////////////////////
  // Driver controller sequencer
  //////////////////////////////////////////////////////////////////////

  // IDLE picks the next sequence, the three shift states share
  // the serializer, LATCH finishes the lat pulses and BLANK waits
  // out the gap after a vsync
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_CONF_SHIFT = 3'd1,
    ST_DATA_SHIFT = 3'd2,
    ST_LATCH      = 3'd3,
    ST_VSYNC      = 3'd4,
    ST_BLANK      = 3'd5
  } ctrl_state_t;

endpackage

/* source/led_panel_top.sv */
`timescale 1ns/100ps
`include "led_panel_defines.svh"

module led_panel_top (
  input  logic                    clock_33,
  input  logic                    nrst,
  input  led_panel_pkg::pattern_t pattern_sel,
  input  logic [6:0]              brightness,
  output logic                    sclk,
  output logic                    lat,
  output logic [`LED_CHAINS-1:0]  sin,
  output logic                    gclk
);

  // Emulator to FIFO
  logic                               word_valid;
  logic [`LED_CHAINS*`PIXEL_BITS-1:0] word_data;
  logic                               word_sof;
  logic                               credit_return;

  // FIFO to controller
  logic                               fifo_empty;
  logic [`LED_CHAINS*`PIXEL_BITS-1:0] fifo_data;
  logic                               fifo_sof;
  logic                               fifo_pop;

  logic                               vsync_done;

  framebuffer_emulator fb_emulator (
    .clock_33      (clock_33),
    .nrst          (nrst),
    .pattern_sel   (pattern_sel),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .word_sof      (word_sof),
    .credit_return (credit_return)
  );

  pixel_fifo rx_fifo (
    .clock_33      (clock_33),
    .nrst          (nrst),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .word_sof      (word_sof),
    .fifo_pop      (fifo_pop),
    .fifo_empty    (fifo_empty),
    .fifo_data     (fifo_data),
    .fifo_sof      (fifo_sof),
    .credit_return (credit_return)
  );

  driver_controller drv_ctrl (
    .clock_33   (clock_33),
    .nrst       (nrst),
    .brightness (brightness),
    .fifo_empty (fifo_empty),
    .fifo_data  (fifo_data),
    .fifo_sof   (fifo_sof),
    .fifo_pop   (fifo_pop),
    .sclk       (sclk),
    .lat        (lat),
    .sin        (sin),
    .vsync_done (vsync_done)
  );

  gclk_generator gclk_gen (
    .clock_33   (clock_33),
    .nrst       (nrst),
    .vsync_done (vsync_done),
    .gclk       (gclk)
  );

endmodule

/* source/pixel_fifo.sv */
`timescale 1ns/100ps
`include "led_panel_defines.svh"

module pixel_fifo (
  input  logic                               clock_33,
  input  logic                               nrst,
  input  logic                               word_valid,
  input  logic [`LED_CHAINS*`PIXEL_BITS-1:0] word_data,
  input  logic                               word_sof,
  input  logic                               fifo_pop,
  output logic                               fifo_empty,
  output logic [`LED_CHAINS*`PIXEL_BITS-1:0] fifo_data,
  output logic                               fifo_sof,
  output logic                               credit_return
);

  localparam int DW = `LED_CHAINS * `PIXEL_BITS;
  localparam int AW = $clog2(`FIFO_DEPTH);

  // Entry is {sof, data}
  logic [DW:0] mem [`FIFO_DEPTH];

  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_pop;

  assign fifo_empty = (wr_ptr == rd_ptr);
  assign do_pop     = fifo_pop & ~fifo_empty;

  // Every word leaving frees one slot for the emulator
  assign credit_return = do_pop;

  // Head is shown without a read request
  assign {fifo_sof, fifo_data} = mem[rd_ptr[AW-1:0]];

  // The sender never exceeds its credits, so no full check here
  always_ff @(posedge clock_33) begin
    if (word_valid) begin
      mem[wr_ptr[AW-1:0]] <= {word_sof, word_data};
    end
  end

  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (word_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

/* testbench/led_panel_tb.sv */
`timescale 1ns/100ps
`include "led_panel_defines.svh"

module led_panel_tb;

  localparam int NUM_ROWS      = 5;
  localparam int CAP_BITS      = `WORDS_PER_LINE * `PIXEL_BITS;
  localparam int LATCH_TIMEOUT = 2000;

  // Bits captured per chain since the last lat fall
  typedef logic [`LED_CHAINS-1:0][CAP_BITS-1:0] capture_t;

  logic                    clock_33;
  logic                    nrst;
  led_panel_pkg::pattern_t pattern_sel;
  logic [6:0]              brightness;
  logic                    sclk;
  logic                    lat;
  logic [`LED_CHAINS-1:0]  sin;
  logic                    gclk;

  // Stimulus table
  string                   row_name   [NUM_ROWS];
  led_panel_pkg::pattern_t row_pat    [NUM_ROWS];
  logic [6:0]              row_bright [NUM_ROWS];

  // Decoded lat sequences, oldest first
  int unsigned ev_width [$];
  int unsigned ev_bits  [$];
  capture_t    ev_data  [$];

  // Chip model state
  capture_t    shift_reg;
  int unsigned bit_count;
  int unsigned lat_pulses;
  int          since_vsync;
  logic        sclk_prev;
  logic        lat_prev;
  logic        gclk_prev;
  string       cur_test;

  led_panel_top DUT (
    .clock_33    (clock_33),
    .nrst        (nrst),
    .pattern_sel (pattern_sel),
    .brightness  (brightness),
    .sclk        (sclk),
    .lat         (lat),
    .sin         (sin),
    .gclk        (gclk)
  );

  initial begin
    clock_33 = 1'b0;
    forever #2 clock_33 = ~clock_33;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and reference rules
  //////////////////////////////////////////////////////////////////////

  task automatic fail_stop();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic report_value(input string what, input longint unsigned exp,
                              input longint unsigned act);
    $display("ERR %s: %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
    fail_stop();
  endtask

  // sclk pulses with lat high for each command
  function automatic int unsigned pulses_for(input driver_conf_pkg::drv_cmd_t cmd);
    case (cmd)
      driver_conf_pkg::CMD_DATA_LATCH: return 1;
      driver_conf_pkg::CMD_VSYNC:      return 3;
      default:                         return 11;
    endcase
  endfunction

  // Brightness in bits 6:0, fixed field everywhere else
  function automatic logic [47:0] expected_conf(input logic [6:0] bright);
    return {driver_conf_pkg::conf_fixed[47:7], bright};
  endfunction

  function automatic logic [15:0] expected_pixel(input led_panel_pkg::pattern_t pat,
                                                 input int c, input int l,
                                                 input int w, input int f);
    case (pat)
      led_panel_pkg::PAT_SOLID:   return 16'hFFFF;
      led_panel_pkg::PAT_RAMP:    return 16'(l * `WORDS_PER_LINE + w + c * 256);
      led_panel_pkg::PAT_CHECKER: return ((l + w + c) % 2 == 1) ? 16'hFFFF : 16'h0000;
      default:                    return 16'(f % 65536);
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Driver chip model
  //////////////////////////////////////////////////////////////////////

  // Sampled at the falling clock edge, away from output changes
  always @(negedge clock_33) begin
    if (!nrst) begin
      shift_reg   = '0;
      bit_count   = 0;
      lat_pulses  = 0;
      since_vsync = -1;
      sclk_prev   = 1'b0;
      lat_prev    = 1'b0;
      gclk_prev   = 1'b0;
    end else begin
      // gclk stays low until the first vsync, then blanks after each one
      if (since_vsync < 0) begin
        assert (gclk == 1'b0) else report_value("gclk before first vsync", 0, 64'(gclk));
      end else begin
        since_vsync++;
        if (since_vsync <= `BLANKING_CYCLES) begin
          assert (gclk == 1'b0) else report_value("gclk in blanking", 0, 64'(gclk));
        end else if (since_vsync == `BLANKING_CYCLES + 1) begin
          assert (gclk == 1'b1) else report_value("gclk restart", 1, 64'(gclk));
        end else begin
          assert (gclk != gclk_prev) else report_value("gclk toggle", 64'(~gclk_prev),
                                                       64'(gclk));
        end
      end
      gclk_prev = gclk;

      if (sclk && !sclk_prev) begin
        if (lat) begin
          lat_pulses++;
        end
        // Later pulses with lat high only count the command
        if (!lat || lat_pulses == 1) begin
          for (int c = 0; c < `LED_CHAINS; c++) begin
            shift_reg[c] = {shift_reg[c][CAP_BITS-2:0], sin[c]};
          end
          bit_count++;
        end
      end

      if (!lat && lat_prev) begin
        ev_width.push_back(lat_pulses);
        ev_bits.push_back(bit_count);
        ev_data.push_back(shift_reg);
        if (lat_pulses == pulses_for(driver_conf_pkg::CMD_VSYNC)) begin
          since_vsync = 0;
        end
        bit_count  = 0;
        lat_pulses = 0;
      end
      sclk_prev = sclk;
      lat_prev  = lat;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequence checks
  //////////////////////////////////////////////////////////////////////

  task automatic expect_latch(input driver_conf_pkg::drv_cmd_t cmd, input int unsigned nbits,
                              output capture_t data);
    int          waited;
    int unsigned width;
    int unsigned bits;
    waited = 0;
    while (ev_width.size() == 0) begin
      if (waited >= LATCH_TIMEOUT) begin
        $display("Timeout in %s: no %s lat sequence came within %0d cycles",
                 cur_test, cmd.name(), LATCH_TIMEOUT);
        fail_stop();
      end
      @(posedge clock_33);
      waited++;
    end
    width = ev_width.pop_front();
    bits  = ev_bits.pop_front();
    data  = ev_data.pop_front();
    assert (width == pulses_for(cmd))
      else report_value({cmd.name(), " lat width"}, 64'(pulses_for(cmd)), 64'(width));
    assert (bits == nbits) else report_value({cmd.name(), " bit count"}, 64'(nbits), 64'(bits));
  endtask

  task automatic check_conf(input logic [6:0] bright);
    capture_t data;
    expect_latch(driver_conf_pkg::CMD_CONF_WRITE, driver_conf_pkg::CONF_BITS, data);
    for (int c = 0; c < `LED_CHAINS; c++) begin
      assert (data[c][47:0] == expected_conf(bright))
        else report_value($sformatf("conf word chain %0d", c), 64'(expected_conf(bright)),
                          64'(data[c][47:0]));
    end
  endtask

  task automatic check_frame(input led_panel_pkg::pattern_t pat, input int frame);
    capture_t    data;
    logic [15:0] exp;
    logic [15:0] act;
    for (int l = 0; l < `LINES; l++) begin
      expect_latch(driver_conf_pkg::CMD_DATA_LATCH, CAP_BITS, data);
      for (int c = 0; c < `LED_CHAINS; c++) begin
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
          exp = expected_pixel(pat, c, l, w, frame);
          act = data[c][(`WORDS_PER_LINE - w) * `PIXEL_BITS - 1 -: `PIXEL_BITS];
          assert (act == exp)
            else report_value($sformatf("frame %0d line %0d chain %0d word %0d",
                                        frame, l, c, w), 64'(exp), 64'(act));
        end
      end
    end
    // Vsync carries only zero bits
    expect_latch(driver_conf_pkg::CMD_VSYNC, driver_conf_pkg::VSYNC_BITS, data);
    for (int c = 0; c < `LED_CHAINS; c++) begin
      assert (data[c][15:0] == 16'h0000)
        else report_value($sformatf("vsync bits chain %0d", c), 0, 64'(data[c][15:0]));
    end
  endtask

  task automatic load_table();
    row_name[0] = "ramp_start";        row_pat[0] = led_panel_pkg::PAT_RAMP;
    row_bright[0] = 7'h40;
    row_name[1] = "solid_same_bright"; row_pat[1] = led_panel_pkg::PAT_SOLID;
    row_bright[1] = 7'h40;
    row_name[2] = "checker_dim";       row_pat[2] = led_panel_pkg::PAT_CHECKER;
    row_bright[2] = 7'h15;
    row_name[3] = "frame_id_dim";      row_pat[3] = led_panel_pkg::PAT_FRAME_ID;
    row_bright[3] = 7'h15;
    row_name[4] = "ramp_full";         row_pat[4] = led_panel_pkg::PAT_RAMP;
    row_bright[4] = 7'h7F;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int frame_num;
    load_table();
    frame_num   = 0;
    cur_test    = "reset";
    nrst        = 1'b0;
    pattern_sel = row_pat[0];
    brightness  = row_bright[0];
    repeat (10) @(posedge clock_33);
    assert ({sclk, lat, sin, gclk} == '0)
      else report_value("outputs in reset", 0, 64'({sclk, lat, sin, gclk}));
    nrst <= 1'b1;

    cur_test = row_name[0];
    check_conf(row_bright[0]);
    check_frame(row_pat[0], frame_num);
    frame_num++;

    for (int r = 1; r < NUM_ROWS; r++) begin
      // Applied in the blanking gap; the next frame was already queued
      pattern_sel <= row_pat[r];
      brightness  <= row_bright[r];
      cur_test = {row_name[r], " handover"};
      if (row_bright[r] != row_bright[r-1]) begin
        check_conf(row_bright[r]);
      end
      check_frame(row_pat[r-1], frame_num);
      frame_num++;
      cur_test = row_name[r];
      check_frame(row_pat[r], frame_num);
      frame_num++;
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
